/* testbench/exec_patterns.txt */
// ctrl pc op rd rs1 rs1_data rs2_data f3 f7 imm  en rd data addr strb sgn wdata target
// ctrl bits: flush stall mem_wait (2..0); en bits: reg_wr mem_rd mem_wr jump (3..0)
0 00000000 00 00 00 00000000 00000000 0 00 00000000 0 00 00000000 00000000 0 0 00000000 00000000
0 00000100 33 01 02 00000005 00000003 0 00 00000000 8 01 00000008 00000000 0 0 00000000 00000000
0 00000104 33 02 02 00000005 00000007 0 20 00000000 8 02 fffffffe 00000000 0 0 00000000 00000000
0 00000108 33 03 02 f0f0f0f0 ff00ff00 7 00 00000000 8 03 f000f000 00000000 0 0 00000000 00000000
0 0000010c 33 04 02 f0f0f0f0 ff00ff00 6 00 00000000 8 04 fff0fff0 00000000 0 0 00000000 00000000
0 00000110 33 05 02 f0f0f0f0 ff00ff00 4 00 00000000 8 05 0ff00ff0 00000000 0 0 00000000 00000000
0 00000114 33 06 02 00000001 00000024 1 00 00000000 8 06 00000010 00000000 0 0 00000000 00000000
0 00000118 33 07 02 80000010 00000004 5 00 00000000 8 07 08000001 00000000 0 0 00000000 00000000
0 0000011c 33 08 02 80000010 00000004 5 20 00000000 8 08 f8000001 00000000 0 0 00000000 00000000
0 00000120 33 09 02 ffffffff 00000001 2 00 00000000 8 09 00000001 00000000 0 0 00000000 00000000
0 00000124 33 0a 02 ffffffff 00000001 3 00 00000000 8 0a 00000000 00000000 0 0 00000000 00000000
0 00000128 13 0b 02 00000010 00000000 0 00 00000fff 8 0b 0000000f 00000000 0 0 00000000 00000000
0 0000012c 13 0c 02 f0000000 00000000 5 20 00000404 8 0c ff000000 00000000 0 0 00000000 00000000
0 00000130 13 0d 02 00000001 00000000 1 20 00000004 0 00 00000000 00000000 0 0 00000000 00000000
0 00000134 37 0e 00 00000000 00000000 0 00 12345abc 8 0e 12345000 00000000 0 0 00000000 00000000
0 00000138 17 0f 00 00000000 00000000 0 00 00001000 8 0f 00001138 00000000 0 0 00000000 00000000
0 0000013c 6f 01 00 00000000 00000000 0 00 00001ff0 9 01 00000140 00000000 0 0 00000000 0000012c
0 00000140 67 05 02 00002003 00000000 0 00 00000004 9 05 00000144 00000000 0 0 00000000 00002006
0 00000144 63 00 01 00000007 00000007 0 00 00000020 1 00 00000000 00000000 0 0 00000000 00000164
0 00000148 63 00 01 00000007 00000008 0 00 00000020 0 00 00000000 00000000 0 0 00000000 00000168
0 0000014c 63 00 01 00000007 00000008 1 00 00001ff8 1 00 00000000 00000000 0 0 00000000 00000144
0 00000150 63 00 01 00000007 00000007 1 00 00000020 0 00 00000000 00000000 0 0 00000000 00000170
0 00000154 63 00 01 ffffffff 00000001 4 00 00000020 1 00 00000000 00000000 0 0 00000000 00000174
0 00000158 63 00 01 00000001 ffffffff 4 00 00000020 0 00 00000000 00000000 0 0 00000000 00000178
0 0000015c 63 00 01 00000001 ffffffff 5 00 00000020 1 00 00000000 00000000 0 0 00000000 0000017c
0 00000160 63 00 01 ffffffff 00000001 5 00 00000020 0 00 00000000 00000000 0 0 00000000 00000180
0 00000164 63 00 01 00000001 ffffffff 6 00 00000020 1 00 00000000 00000000 0 0 00000000 00000184
0 00000168 63 00 01 ffffffff 00000001 6 00 00000020 0 00 00000000 00000000 0 0 00000000 00000188
0 0000016c 63 00 01 ffffffff 00000001 7 00 00000020 1 00 00000000 00000000 0 0 00000000 0000018c
0 00000170 63 00 01 00000001 ffffffff 7 00 00000020 0 00 00000000 00000000 0 0 00000000 00000190
0 00000174 03 06 03 00001000 00000000 0 00 00000fff 4 06 00000000 00000fff 1 1 00000000 00000000
0 00000178 03 07 03 00001000 00000000 1 00 00000002 4 07 00000000 00001002 3 1 00000000 00000000
0 0000017c 03 08 03 00001000 00000000 2 00 000007fc 4 08 00000000 000017fc f 0 00000000 00000000
0 00000180 03 09 03 00002000 00000000 4 00 00000003 4 09 00000000 00002003 1 0 00000000 00000000
0 00000184 03 0a 03 00002000 00000000 5 00 00000800 4 0a 00000000 00001800 3 0 00000000 00000000
0 00000188 23 00 03 00003000 000000aa 0 00 00000001 2 00 00000000 00003001 1 0 000000aa 00000000
0 0000018c 23 00 03 00003000 0000beef 1 00 00000ffe 2 00 00000000 00002ffe 3 0 0000beef 00000000
0 00000190 23 00 03 00003000 deadbeef 2 00 00000008 2 00 00000000 00003008 f 0 deadbeef 00000000
0 00000194 33 01 02 00000002 00000003 0 00 00000000 8 01 00000005 00000000 0 0 00000000 00000000
1 00000198 13 02 02 00000010 00000000 0 00 00000001 8 01 00000005 00000000 0 0 00000000 00000000
1 0000019c 33 03 02 00000009 00000001 0 20 00000000 8 01 00000005 00000000 0 0 00000000 00000000
0 00000198 13 02 02 00000010 00000000 0 00 00000001 8 02 00000011 00000000 0 0 00000000 00000000
2 0000019c 33 03 02 00000001 00000001 0 00 00000000 0 00 00000000 00000000 0 0 00000000 00000000
4 000001a0 6f 01 00 00000000 00000000 0 00 00000010 0 00 00000000 00000000 0 0 00000000 00000000
5 000001a4 03 04 03 00001000 00000000 2 00 00000000 0 00 00000000 00000000 0 0 00000000 00000000
1 000001a8 33 05 02 00000001 00000001 0 00 00000000 0 00 00000000 00000000 0 0 00000000 00000000
0 000001ac 63 00 01 00000001 00000002 1 00 00000040 1 00 00000000 00000000 0 0 00000000 000001ec
3 000001b0 23 00 03 00003000 00000001 2 00 00000000 0 00 00000000 00000000 0 0 00000000 00000000
0 00000000 00 00 00 00000000 00000000 0 00 00000000 0 00 00000000 00000000 0 0 00000000 00000000

/* rv_exec.f */
hdl/rv_exec_pkg.sv
hdl/exec_issue_reg.sv
hdl/exec_alu.sv
hdl/exec_mem_agu.sv
hdl/exec_branch.sv
hdl/exec_top.sv
testbench/tb_exec_top.sv

/* Bender.yml */
package:
  name: rv_exec

sources:
  - files:
      - hdl/rv_exec_pkg.sv
      - hdl/exec_issue_reg.sv
      - hdl/exec_alu.sv
      - hdl/exec_mem_agu.sv
      - hdl/exec_branch.sv
      - hdl/exec_top.sv
  - target: simulation
    files:
      - testbench/tb_exec_top.sv

/* testbench/tb_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top;

    localparam int    clk_period   = 100;
    localparam int    drive_delay  = 10;
    localparam int    reset_cycles = 4;
    localparam int    n_cols       = 18;
    localparam int    max_steps    = 64;
    localparam string pat_file     = "testbench/exec_patterns.txt";

    logic                      CLK;
    logic                      arst_n;
    logic                      flush;
    logic                      stall;
    logic                      mem_wait;
    rv_exec_pkg::issue_t       issue_in;
    wire rv_exec_pkg::reg_wr_t reg_wr;
    wire rv_exec_pkg::mem_rd_t mem_rd;
    wire rv_exec_pkg::mem_wr_t mem_wr;
    wire rv_exec_pkg::jump_t   jump;

    logic [31:0] pat [0:n_cols*max_steps-1]; // one row of n_cols words per step
    int          n_steps;
    int          n_checks;
    int          n_errors;
    bit          pat_ready;

    exec_top u_exec_top (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .issue_in (issue_in),
        .reg_wr   (reg_wr),
        .mem_rd   (mem_rd),
        .mem_wr   (mem_wr),
        .jump     (jump)
    );

    always #(clk_period/2) CLK = ~CLK;

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // inactive requests are all zero and the jump target is checked as given
    task automatic check_outputs(input logic [3:0] en, input logic [31:0] rd,
                                 input logic [31:0] data, input logic [31:0] addr,
                                 input logic [31:0] strb, input logic [31:0] sgn,
                                 input logic [31:0] wdata, input logic [31:0] target);
        compare_field("reg_wr.en", en[3], reg_wr.en);
        compare_field("reg_wr.rd", en[3] ? rd : 32'h0, reg_wr.rd);
        compare_field("reg_wr.data", en[3] ? data : 32'h0, reg_wr.data);
        compare_field("mem_rd.en", en[2], mem_rd.en);
        compare_field("mem_rd.rd", en[2] ? rd : 32'h0, mem_rd.rd);
        compare_field("mem_rd.addr", en[2] ? addr : 32'h0, mem_rd.addr);
        compare_field("mem_rd.strb", en[2] ? strb : 32'h0, mem_rd.strb);
        compare_field("mem_rd.is_signed", en[2] ? sgn : 32'h0, mem_rd.is_signed);
        compare_field("mem_wr.en", en[1], mem_wr.en);
        compare_field("mem_wr.addr", en[1] ? addr : 32'h0, mem_wr.addr);
        compare_field("mem_wr.strb", en[1] ? strb : 32'h0, mem_wr.strb);
        compare_field("mem_wr.data", en[1] ? wdata : 32'h0, mem_wr.data);
        compare_field("jump.taken", en[0], jump.taken);
        compare_field("jump.target", target, jump.target);
    endtask

    task automatic check_step(input int s);
        int b;
        b = s * n_cols;
        check_outputs(pat[b+10][3:0], pat[b+11], pat[b+12], pat[b+13],
                      pat[b+14], pat[b+15], pat[b+16], pat[b+17]);
    endtask

    task automatic drive_step(input int s);
        int b;
        b                 = s * n_cols;
        flush             = pat[b][2];
        stall             = pat[b][1];
        mem_wait          = pat[b][0];
        issue_in.pc       = pat[b+1];
        issue_in.opcode   = pat[b+2][6:0];
        issue_in.rd       = pat[b+3][4:0];
        issue_in.rs1      = pat[b+4][4:0];
        issue_in.rs1_data = pat[b+5];
        issue_in.rs2_data = pat[b+6];
        issue_in.funct3   = pat[b+7][2:0];
        issue_in.funct7   = pat[b+8][6:0];
        issue_in.imm      = pat[b+9];
    endtask

    task automatic load_patterns();
        int fd;
        int c;
        bit bad;
        bad = 1'b0;
        fd  = $fopen(pat_file, "r");
        if (fd == 0) begin
            $display("pattern file %s could not be opened", pat_file);
            n_errors++;
            return;
        end
        $fclose(fd);
        $readmemh(pat_file, pat);
        while (n_steps < max_steps && !$isunknown(pat[n_steps*n_cols])) begin
            for (c = 0; c < n_cols; c++) begin
                if ($isunknown(pat[n_steps*n_cols + c])) begin
                    bad = 1'b1; // short last row
                end
            end
            n_steps++;
        end
        if (bad) begin
            $display("pattern file %s has a step with missing columns", pat_file);
            n_errors++;
            n_steps = 0;
        end else if (n_steps == 0) begin
            $display("pattern file %s holds no test steps", pat_file);
            n_errors++;
        end
    endtask

    initial begin
        wait (pat_ready);
        #((n_steps + reset_cycles + 10) * clk_period);
        $display("watchdog expired after %0d clock periods, run did not finish",
                 n_steps + reset_cycles + 10);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int s;
        CLK       = 1'b0;
        arst_n    = 1'b0;
        flush     = 1'b0;
        stall     = 1'b0;
        mem_wait  = 1'b0;
        issue_in  = '0;
        n_steps   = 0;
        n_checks  = 0;
        n_errors  = 0;
        pat_ready = 1'b0;
        load_patterns();
        pat_ready = 1'b1;

        repeat (reset_cycles - 1) @(posedge CLK);
        #drive_delay;
        check_outputs(4'h0, 0, 0, 0, 0, 0, 0, 0); // still in reset
        @(posedge CLK);
        #drive_delay;
        arst_n = 1'b1;

        // each step is checked one edge after it was driven
        for (s = 0; s <= n_steps; s++) begin
            @(posedge CLK);
            #drive_delay;
            if (s > 0) begin
                check_step(s - 1);
            end
            if (s < n_steps) begin
                drive_step(s);
            end
        end

        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top (
    input  wire                       CLK,
    input  wire                       arst_n,
    input  wire                       flush,
    input  wire                       stall,
    input  wire                       mem_wait,
    input  wire  rv_exec_pkg::issue_t  issue_in,
    output wire  rv_exec_pkg::reg_wr_t reg_wr,
    output wire  rv_exec_pkg::mem_rd_t mem_rd,
    output wire  rv_exec_pkg::mem_wr_t mem_wr,
    output wire  rv_exec_pkg::jump_t   jump
);

    wire rv_exec_pkg::issue_t issue; // captured instruction

    exec_issue_reg u_issue_reg (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .issue_in (issue_in),
        .issue    (issue)
    );

    exec_alu u_alu (
        .issue  (issue),
        .reg_wr (reg_wr)
    );

    exec_mem_agu u_mem_agu (
        .issue  (issue),
        .mem_rd (mem_rd),
        .mem_wr (mem_wr)
    );

    exec_branch u_branch (
        .issue (issue),
        .jump  (jump)
    );

endmodule

`default_nettype wire

/* hdl/exec_branch.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_branch (
    input  wire rv_exec_pkg::issue_t issue,
    output rv_exec_pkg::jump_t       jump
);

    logic signed [rv_exec_pkg::xlen-1:0] rs1_s;
    logic signed [rv_exec_pkg::xlen-1:0] rs2_s;
    logic        [rv_exec_pkg::xlen-1:0] jalr_sum;
    logic                               cond;
    logic                               cond_ok;

    assign rs1_s    = issue.rs1_data;
    assign rs2_s    = issue.rs2_data;
    assign jalr_sum = issue.rs1_data + rv_exec_pkg::imm_i(issue.imm);

    always_comb begin
        cond    = 1'b0;
        cond_ok = 1'b1;
        case (issue.funct3)
            rv_exec_pkg::f3_beq:  cond = (issue.rs1_data == issue.rs2_data);
            rv_exec_pkg::f3_bne:  cond = (issue.rs1_data != issue.rs2_data);
            rv_exec_pkg::f3_blt:  cond = (rs1_s < rs2_s);
            rv_exec_pkg::f3_bge:  cond = (rs1_s >= rs2_s);
            rv_exec_pkg::f3_bltu: cond = (issue.rs1_data < issue.rs2_data);
            rv_exec_pkg::f3_bgeu: cond = (issue.rs1_data >= issue.rs2_data);
            default:              cond_ok = 1'b0;
        endcase
    end

    always_comb begin
        jump = '0;
        case (issue.opcode)
            rv_exec_pkg::op_branch: begin
                if (cond_ok) begin
                    jump.taken  = cond;
                    jump.target = issue.pc + rv_exec_pkg::imm_b(issue.imm);
                end
            end
            rv_exec_pkg::op_jal: begin
                jump.taken  = 1'b1;
                jump.target = issue.pc + rv_exec_pkg::imm_b(issue.imm);
            end
            rv_exec_pkg::op_jalr: begin
                jump.taken  = 1'b1;
                jump.target = {jalr_sum[rv_exec_pkg::xlen-1:1], 1'b0}; // clear bit 0
            end
            default: begin
                jump = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/exec_mem_agu.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_mem_agu (
    input  wire rv_exec_pkg::issue_t issue,
    output rv_exec_pkg::mem_rd_t     mem_rd,
    output rv_exec_pkg::mem_wr_t     mem_wr
);

    logic [rv_exec_pkg::xlen-1:0]   addr;
    logic [rv_exec_pkg::strb_w-1:0] strb;
    logic                           sign_ext;
    logic                           size_ok;
    logic                           is_unsigned;

    assign addr = issue.rs1_data + rv_exec_pkg::imm_i(issue.imm);

    // size code to strobe
    always_comb begin
        strb        = '0;
        sign_ext    = 1'b0;
        size_ok     = 1'b1;
        is_unsigned = 1'b0;
        case (issue.funct3)
            rv_exec_pkg::f3_byte: begin
                strb     = rv_exec_pkg::strb_byte;
                sign_ext = 1'b1;
            end
            rv_exec_pkg::f3_half: begin
                strb     = rv_exec_pkg::strb_half;
                sign_ext = 1'b1;
            end
            rv_exec_pkg::f3_word: begin
                strb = rv_exec_pkg::strb_word;
            end
            rv_exec_pkg::f3_byte_u: begin
                strb        = rv_exec_pkg::strb_byte;
                is_unsigned = 1'b1;
            end
            rv_exec_pkg::f3_half_u: begin
                strb        = rv_exec_pkg::strb_half;
                is_unsigned = 1'b1;
            end
            default: begin
                size_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        mem_rd = '0;
        if (issue.opcode == rv_exec_pkg::op_load && size_ok) begin
            mem_rd.en        = 1'b1;
            mem_rd.rd        = issue.rd;
            mem_rd.addr      = addr;
            mem_rd.strb      = strb;
            mem_rd.is_signed = sign_ext; // lb, lh only
        end
    end

    always_comb begin
        mem_wr = '0;
        // no unsigned store encodings
        if (issue.opcode == rv_exec_pkg::op_store && size_ok && !is_unsigned) begin
            mem_wr.en   = 1'b1;
            mem_wr.addr = addr;
            mem_wr.strb = strb;
            mem_wr.data = issue.rs2_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/exec_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  wire rv_exec_pkg::issue_t issue,
    output rv_exec_pkg::reg_wr_t     reg_wr
);

    logic                               is_imm;
    logic                               f7_base;
    logic                               f7_alt;
    logic        [rv_exec_pkg::xlen-1:0] opa;
    logic        [rv_exec_pkg::xlen-1:0] opb;
    logic signed [rv_exec_pkg::xlen-1:0] opa_s;
    logic signed [rv_exec_pkg::xlen-1:0] opb_s;
    logic        [4:0]                  shamt;
    logic        [rv_exec_pkg::xlen-1:0] int_res;
    logic                               int_ok;

    assign is_imm  = (issue.opcode == rv_exec_pkg::op_imm);
    assign f7_base = (issue.funct7 == rv_exec_pkg::funct7_base);
    assign f7_alt  = (issue.funct7 == rv_exec_pkg::funct7_alt);

    assign opa   = issue.rs1_data;
    assign opb   = is_imm ? rv_exec_pkg::imm_i(issue.imm) : issue.rs2_data;
    assign opa_s = opa;
    assign opb_s = opb;
    assign shamt = opb[4:0]; // imm_i keeps imm[4:0] in place

    // shared integer datapath for op_reg and op_imm
    always_comb begin
        int_res = '0;
        int_ok  = 1'b0;
        case (issue.funct3)
            rv_exec_pkg::f3_add_sub: begin
                int_ok  = is_imm | f7_base | f7_alt;
                int_res = (!is_imm && f7_alt) ? opa - opb : opa + opb;
            end
            rv_exec_pkg::f3_sll: begin
                int_ok  = f7_base; // slli too
                int_res = opa << shamt;
            end
            rv_exec_pkg::f3_slt: begin
                int_ok  = is_imm | f7_base;
                int_res = {{(rv_exec_pkg::xlen-1){1'b0}}, opa_s < opb_s};
            end
            rv_exec_pkg::f3_sltu: begin
                int_ok  = is_imm | f7_base;
                int_res = {{(rv_exec_pkg::xlen-1){1'b0}}, opa < opb};
            end
            rv_exec_pkg::f3_xor: begin
                int_ok  = is_imm | f7_base;
                int_res = opa ^ opb;
            end
            rv_exec_pkg::f3_srl_sra: begin
                int_ok = f7_base | f7_alt;
                if (f7_alt) begin
                    int_res = opa_s >>> shamt;
                end else begin
                    int_res = opa >> shamt;
                end
            end
            rv_exec_pkg::f3_or: begin
                int_ok  = is_imm | f7_base;
                int_res = opa | opb;
            end
            rv_exec_pkg::f3_and: begin
                int_ok  = is_imm | f7_base;
                int_res = opa & opb;
            end
            default: begin
                int_ok  = 1'b0;
                int_res = '0;
            end
        endcase
    end

    always_comb begin
        reg_wr = '0;
        case (issue.opcode)
            rv_exec_pkg::op_reg,
            rv_exec_pkg::op_imm: begin
                if (int_ok) begin
                    reg_wr.en   = 1'b1;
                    reg_wr.rd   = issue.rd;
                    reg_wr.data = int_res;
                end
            end
            rv_exec_pkg::op_lui: begin
                reg_wr.en   = 1'b1;
                reg_wr.rd   = issue.rd;
                reg_wr.data = rv_exec_pkg::imm_u(issue.imm);
            end
            rv_exec_pkg::op_auipc: begin
                reg_wr.en   = 1'b1;
                reg_wr.rd   = issue.rd;
                reg_wr.data = issue.pc + rv_exec_pkg::imm_u(issue.imm);
            end
            rv_exec_pkg::op_jal,
            rv_exec_pkg::op_jalr: begin
                reg_wr.en   = 1'b1;
                reg_wr.rd   = issue.rd;
                reg_wr.data = issue.pc + rv_exec_pkg::insn_bytes; // link
            end
            default: begin
                reg_wr = '0; // loads, stores, branches, bubble
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/exec_issue_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_issue_reg (
    input  wire                 CLK,
    input  wire                 arst_n,
    input  wire                 flush,
    input  wire                 stall,
    input  wire                 mem_wait,
    input  wire rv_exec_pkg::issue_t issue_in,
    output rv_exec_pkg::issue_t issue
);

    // all-zero instruction whose opcode 0 decodes to nothing
    localparam rv_exec_pkg::issue_t bubble = '0;

    logic bubble_in;
    logic load_in;

    // flush and stall win over mem_wait
    assign bubble_in = flush | stall;
    assign load_in   = ~bubble_in & ~mem_wait;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            issue <= bubble;
        end else if (bubble_in) begin
            issue <= bubble; // input during stall is dropped
        end else if (load_in) begin
            issue <= issue_in;
        end
        // mem_wait alone keeps the current instruction
    end

endmodule

`default_nettype wire

/* hdl/rv_exec_pkg.sv */
`default_nettype none

package rv_exec_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int strb_w     = 4;
    localparam int insn_bytes = 4;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000; // sub, sra

    localparam logic [strb_w-1:0] strb_byte = 4'b0001;
    localparam logic [strb_w-1:0] strb_half = 4'b0011;
    localparam logic [strb_w-1:0] strb_word = 4'b1111;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [6:0]            opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [xlen-1:0]       imm;
    } issue_t;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } reg_wr_t;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       addr;
        logic [strb_w-1:0]     strb;
        logic                  is_signed;
    } mem_rd_t;

    typedef struct packed {
        logic              en;
        logic [xlen-1:0]   addr;
        logic [strb_w-1:0] strb;
        logic [xlen-1:0]   data;
    } mem_wr_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } jump_t;

    function automatic logic [xlen-1:0] imm_i(input logic [xlen-1:0] imm);
        return {{(xlen-12){imm[11]}}, imm[11:0]};
    endfunction

    function automatic logic [xlen-1:0] imm_b(input logic [xlen-1:0] imm);
        return {{(xlen-13){imm[12]}}, imm[12:1], 1'b0}; // bit 0 always zero
    endfunction

    function automatic logic [xlen-1:0] imm_u(input logic [xlen-1:0] imm);
        return {imm[31:12], 12'b0};
    endfunction

endpackage

`default_nettype wire
